//--- Bender.yml
package:
  name: lane_unit

sources:
  - verilog/lane_pkg.sv
  - verilog/pipe_reg.sv
  - verilog/index_unit.sv
  - verilog/reg_bank.sv
  - verilog/mask_reg.sv
  - verilog/exec_unit.sv
  - verilog/lane_unit.sv
  - target: simulation
    files:
      - sim/lane_unit_tb.sv

//--- lane_unit.f
verilog/lane_pkg.sv
verilog/pipe_reg.sv
verilog/index_unit.sv
verilog/reg_bank.sv
verilog/mask_reg.sv
verilog/exec_unit.sv
verilog/lane_unit.sv
sim/lane_unit_tb.sv

//--- sim/lane_cases.txt
# gap op s1_rel s1 s2_rel s2 dst_rel dst masked mask_sel scalar thread_id exp_data exp_written
# op: 0 add 1 sub 2 mul 3 and 4 or 5 xor 6 slt 7 movs; gap is idle cycles before issue, hex values
4 4 0 30 0 31 0 0 0 0 00000000 0 00000000 1
4 7 0 0 0 0 0 1 0 0 12345678 0 12345678 1
4 7 0 0 0 0 0 2 0 0 0000abcd 0 0000abcd 1
4 0 0 1 0 2 0 3 0 0 00000000 0 12350245 1
4 1 0 1 0 2 0 4 0 0 00000000 0 1233aaab 1
4 2 0 2 0 2 0 5 0 0 00000000 0 734b8229 1
4 3 0 1 0 2 0 6 0 0 00000000 0 00000248 1
4 4 0 1 0 2 0 7 0 0 00000000 0 1234fffd 1
4 5 0 1 0 2 0 8 0 0 00000000 0 1234fdb5 1
4 7 0 0 0 0 1 2 0 0 cafef00d 3 cafef00d 1
4 4 0 5 0 0 0 9 0 0 00000000 0 cafef00d 1
4 7 0 0 0 0 1 3 0 0 00000064 3 00000064 1
4 1 1 2 1 3 0 11 0 0 00000000 3 cafeefa9 1
4 6 0 1 0 2 0 1 0 0 00000000 0 00000000 1
4 6 0 2 0 1 0 2 0 0 00000000 0 00000001 1
4 7 0 0 0 0 0 12 0 0 fffffff0 0 fffffff0 1
4 6 0 12 0 0 0 3 0 0 00000000 0 00000001 1
4 7 0 0 0 0 0 13 1 1 deadbeef 0 deadbeef 0
4 4 0 13 0 0 0 14 0 0 00000000 0 00000000 1
4 7 0 0 0 0 0 13 1 2 0badf00d 0 0badf00d 1
4 7 0 0 0 0 0 20 0 0 11111111 0 11111111 1
0 7 0 0 0 0 0 21 0 0 22222222 0 22222222 1
0 0 0 1 0 2 0 22 0 0 00000000 0 12350245 1
0 5 0 7 0 8 0 23 0 0 00000000 0 00000248 1
4 0 0 20 0 21 0 24 0 0 00000000 0 33333333 1

//--- sim/lane_unit_tb.sv
// Testbench for the SIMT lane, replaying commands from a case file and checking every commit
module lane_unit_tb;
	import lane_pkg::*;

	// Expected commit, with the en-high edge count at issue
	typedef struct packed {
		data_t data;
		logic written;
		logic [31:0] issue;
	} expected_t;

	logic clock = 1'b0;
	logic reset;
	logic en;
	command_t command;
	thread_id_t thread_id;
	logic commit;
	data_t scalar_data;
	logic written;

	command_t case_cmd[$];
	thread_id_t case_thread[$];
	int case_gap[$];
	data_t case_data[$];
	logic case_written[$];
	expected_t pending[$];

	logic [31:0] rng_state = 32'd9;
	int en_high_edges = 0;
	int cycle_count = 0;
	int cycle_limit = 1000;

	lane_unit lane_unit_inst (
		.clock(clock),
		.reset(reset),
		.en(en),
		.command(command),
		.thread_id(thread_id),
		.commit(commit),
		.scalar_data(scalar_data),
		.written(written)
	);

	always #10 clock = ~clock;

	//////////////////////////////
	// Helpers
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic match_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("TEST FAILED");
			$display("mismatch %s: got %h, expected %h", name, actual, expected);
			$fatal(1);
		end
	endtask

	task automatic load_cases;
		int fd;
		int fields;
		string line;
		int gap, op, s1_rel, s1, s2_rel, s2, d_rel, d, masked, mask_sel, tid, exp_written;
		logic [31:0] scalar;
		logic [31:0] exp_data;
		command_t cmd;
		fd = $fopen("sim/lane_cases.txt", "r");
		if (fd == 0) begin
			$display("TEST FAILED");
			$display("could not open the case file sim/lane_cases.txt");
			$fatal(1);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				// Comment lines start with a hash
				if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %h %d %h %d",
						gap, op, s1_rel, s1, s2_rel, s2, d_rel, d, masked, mask_sel,
						scalar, tid, exp_data, exp_written);
					if (fields == 14) begin
						cmd = '0;
						cmd.valid = 1'b1;
						cmd.op = op_t'(op);
						cmd.src1.rel = s1_rel[0];
						cmd.src1.idx = reg_idx_t'(s1);
						cmd.src2.rel = s2_rel[0];
						cmd.src2.idx = reg_idx_t'(s2);
						cmd.dst.rel = d_rel[0];
						cmd.dst.idx = reg_idx_t'(d);
						cmd.masked = masked[0];
						cmd.mask_sel = mask_idx_t'(mask_sel);
						cmd.scalar = scalar;
						case_cmd.push_back(cmd);
						case_thread.push_back(thread_id_t'(tid));
						case_gap.push_back(gap);
						case_data.push_back(exp_data);
						case_written.push_back(exp_written[0]);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Random stall while earlier commands are still in the pipe, idle gap, then issue
	task automatic issue_case(input int i);
		int stalls;
		expected_t entry;
		stalls = 0;
		// Bursts stay back to back
		if (case_gap[i] > 0 && pending.size() != 0) begin
			rng_state = next_random(rng_state);
			stalls = int'(rng_state[1:0]);
		end
		repeat (stalls) begin
			command = '0;
			en = 1'b0;
			@(posedge clock);
			#2;
		end
		repeat (case_gap[i]) begin
			command = '0;
			en = 1'b1;
			@(posedge clock);
			#2;
		end
		command = case_cmd[i];
		thread_id = case_thread[i];
		en = 1'b1;
		entry.data = case_data[i];
		entry.written = case_written[i];
		entry.issue = en_high_edges;
		pending.push_back(entry);
		@(posedge clock);
		#2;
		command = '0;
	endtask

	//////////////////////////////
	// Edge counters and timeout
	always @(posedge clock) begin
		if (!reset && en) begin
			en_high_edges <= en_high_edges + 1;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("TEST FAILED");
			$display("timeout after %0d cycles with commits still missing", cycle_count);
			$fatal(1);
		end
	end

	//////////////////////////////
	// Commit monitor
	// Five en-high edges from drive to commit, stalls excluded
	always @(negedge clock) begin : commit_monitor
		expected_t entry;
		if (!reset && commit) begin
			if (pending.size() == 0) begin
				$display("TEST FAILED");
				$display("commit seen while no command was pending");
				$fatal(1);
			end else begin
				entry = pending.pop_front();
				match_value("scalar_data", scalar_data, entry.data);
				match_value("written", 32'(written), 32'(entry.written));
				match_value("latency", en_high_edges - entry.issue, 32'd5);
			end
		end
	end

	//////////////////////////////
	// Stimulus
	initial begin
		reset = 1'b1;
		en = 1'b0;
		command = '0;
		thread_id = '0;
		load_cases();
		cycle_limit = case_gap.size() * 10 + 100;
		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;
		en = 1'b1;
		@(negedge clock);
		match_value("commit", 32'(commit), 32'd0);
		match_value("written", 32'(written), 32'd0);
		@(posedge clock);
		#2;
		for (int i = 0; i < case_gap.size(); i++) begin
			issue_case(i);
		end
		while (pending.size() != 0) begin
			@(posedge clock);
		end
		// A few quiet cycles to catch stray commits
		repeat (8) @(posedge clock);
		$display("TEST OK");
		$finish;
	end

endmodule

//--- verilog/exec_unit.sv
// Execute stage: arithmetic, logic and compare, forming write-back, mask write and commit
module exec_unit (
	input logic clock,
	input logic reset,
	input logic en,
	input lane_pkg::read_stage_t stage,
	input logic mask_bit,
	output lane_pkg::mask_idx_t mask_sel,
	output lane_pkg::wb_t wb,
	output logic mask_we,
	output lane_pkg::mask_idx_t mask_widx,
	output logic mask_wbit,
	output logic commit,
	output lane_pkg::data_t scalar_data,
	output logic written
);
	import lane_pkg::*;

	data_t result;
	logic is_cmp;
	logic active;

	// Mask bit lookup for the command in this stage
	assign mask_sel = stage.mask_sel;

	// Unmasked, or masked with its bit set
	assign active = ~stage.masked | mask_bit;
	assign is_cmp = (stage.op == op_slt);

	//////////////////////////////
	// ALU
	always_comb begin
		case (stage.op)
			op_add: result = stage.data1 + stage.data2;
			op_sub: result = stage.data1 - stage.data2;
			op_mul: result = stage.data1 * stage.data2;
			op_and: result = stage.data1 & stage.data2;
			op_or: result = stage.data1 | stage.data2;
			op_xor: result = stage.data1 ^ stage.data2;
			op_slt: result = data_t'($signed(stage.data1) < $signed(stage.data2));
			op_movs: result = stage.scalar;
			default: result = '0;
		endcase
	end

	//////////////////////////////
	// Output register
	always_ff @(posedge clock) begin
		if (reset) begin
			wb <= '0;
			mask_we <= 1'b0;
			mask_widx <= '0;
			mask_wbit <= 1'b0;
			commit <= 1'b0;
			scalar_data <= '0;
			written <= 1'b0;
		end else if (en) begin
			wb.valid <= stage.valid;
			wb.we <= stage.valid & active & ~is_cmp;
			wb.dst <= stage.dst;
			wb.data <= result;
			mask_we <= stage.valid & active & is_cmp;
			mask_widx <= stage.dst[$bits(mask_idx_t)-1:0];
			mask_wbit <= result[0];
			// Disabled commands still commit, only without a write
			commit <= stage.valid;
			scalar_data <= result;
			written <= stage.valid & active;
		end else begin
			// Stalled, so strobes drop and nothing commits twice
			wb.valid <= 1'b0;
			wb.we <= 1'b0;
			mask_we <= 1'b0;
			commit <= 1'b0;
			written <= 1'b0;
		end
	end

	// A command writes either a register or a mask bit
	one_target: assert property (
		@(posedge clock) disable iff (reset)
		!(wb.we && mask_we)
	);

endmodule

//--- verilog/index_unit.sv
// Index unit that offsets a thread-relative register index by the SIMT thread ID
module index_unit (
	input lane_pkg::operand_t operand,
	input lane_pkg::thread_id_t thread_id,
	output lane_pkg::reg_idx_t index
);
	import lane_pkg::*;

	reg_idx_t thread_offset;
	reg_idx_t window_index;

	// Thread ID as a register offset
	assign thread_offset = reg_idx_t'(thread_id);

	// Wraps modulo the register count, so each thread
	// sees its own window of the 32 registers
	assign window_index = operand.idx + thread_offset;

	// Absolute operands pass unchanged
	assign index = operand.rel ? window_index : operand.idx;

endmodule

//--- verilog/lane_pkg.sv
// Lane package with the sizes, opcodes and stage payloads of one SIMT execution lane
package lane_pkg;

	//////////////////////////////
	// Sizes
	localparam int data_width = 32;
	localparam int reg_count = 32;
	localparam int reg_idx_width = $clog2(reg_count);
	// Registers split evenly over the even and odd bank
	localparam int bank_rows = reg_count / 2;
	localparam int row_width = $clog2(bank_rows);
	localparam int mask_count = 8;
	localparam int thread_id_width = 5;

	typedef logic [data_width-1:0] data_t;
	typedef logic [reg_idx_width-1:0] reg_idx_t;
	typedef logic [row_width-1:0] row_t;
	typedef logic [$clog2(mask_count)-1:0] mask_idx_t;
	typedef logic [thread_id_width-1:0] thread_id_t;

	//////////////////////////////
	// Opcodes
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_mul = 3'd2,
		op_and = 3'd3,
		op_or = 3'd4,
		op_xor = 3'd5,
		op_slt = 3'd6,
		op_movs = 3'd7
	} op_t;

	//////////////////////////////
	// Command and stage payloads
	// Register index, thread-relative when rel is set
	typedef struct packed {
		logic rel;
		reg_idx_t idx;
	} operand_t;

	typedef struct packed {
		logic valid;
		op_t op;
		operand_t src1;
		operand_t src2;
		// Low bits name the mask bit for op_slt
		operand_t dst;
		logic masked;
		mask_idx_t mask_sel;
		data_t scalar;
	} command_t;

	// After index update, all indices effective
	typedef struct packed {
		logic valid;
		op_t op;
		reg_idx_t src1;
		reg_idx_t src2;
		reg_idx_t dst;
		logic masked;
		mask_idx_t mask_sel;
		data_t scalar;
	} idx_stage_t;

	typedef struct packed {
		logic valid;
		op_t op;
		reg_idx_t dst;
		logic masked;
		mask_idx_t mask_sel;
		data_t scalar;
		data_t data1;
		data_t data2;
	} read_stage_t;

	typedef struct packed {
		logic valid;
		logic we;
		reg_idx_t dst;
		data_t data;
	} wb_t;

endpackage

//--- verilog/lane_unit.sv
// SIMT execution lane: command capture, index update, banked register read and execute
module lane_unit (
	input logic clock,
	input logic reset,
	input logic en,
	input lane_pkg::command_t command,
	input lane_pkg::thread_id_t thread_id,
	output logic commit,
	output lane_pkg::data_t scalar_data,
	output logic written
);
	import lane_pkg::*;

	command_t cmd_q;
	thread_id_t thread_q;
	reg_idx_t src1_eff;
	reg_idx_t src2_eff;
	reg_idx_t dst_eff;
	idx_stage_t idx_next;
	idx_stage_t idx_q;
	read_stage_t rd_ctl;
	reg_idx_t rd_src1;
	reg_idx_t rd_src2;
	row_t row1;
	row_t row2;
	data_t even_rdata1;
	data_t even_rdata2;
	data_t odd_rdata1;
	data_t odd_rdata2;
	read_stage_t read_next;
	read_stage_t read_q;
	wb_t wb;
	logic even_we;
	logic odd_we;
	logic mask_bit;
	mask_idx_t mask_sel;
	logic mask_we;
	mask_idx_t mask_widx;
	logic mask_wbit;

	//////////////////////////////
	// Command capture
	pipe_reg #(.payload_t(command_t)) cmd_reg (
		.clock(clock),
		.reset(reset),
		.en(en),
		.d(command),
		.q(cmd_q)
	);

	// Thread ID travels with its command
	always_ff @(posedge clock) begin
		if (reset) begin
			thread_q <= '0;
		end else if (en) begin
			thread_q <= thread_id;
		end
	end

	//////////////////////////////
	// Index update
	index_unit src1_index (
		.operand(cmd_q.src1),
		.thread_id(thread_q),
		.index(src1_eff)
	);

	index_unit src2_index (
		.operand(cmd_q.src2),
		.thread_id(thread_q),
		.index(src2_eff)
	);

	index_unit dst_index (
		.operand(cmd_q.dst),
		.thread_id(thread_q),
		.index(dst_eff)
	);

	always_comb begin
		idx_next.valid = cmd_q.valid;
		idx_next.op = cmd_q.op;
		idx_next.src1 = src1_eff;
		idx_next.src2 = src2_eff;
		idx_next.dst = dst_eff;
		idx_next.masked = cmd_q.masked;
		idx_next.mask_sel = cmd_q.mask_sel;
		idx_next.scalar = cmd_q.scalar;
	end

	pipe_reg #(.payload_t(idx_stage_t)) idx_reg (
		.clock(clock),
		.reset(reset),
		.en(en),
		.d(idx_next),
		.q(idx_q)
	);

	//////////////////////////////
	// Register read
	// During a stall the held command re-reads its own rows
	assign row1 = en ? idx_q.src1[reg_idx_width-1:1] : rd_src1[reg_idx_width-1:1];
	assign row2 = en ? idx_q.src2[reg_idx_width-1:1] : rd_src2[reg_idx_width-1:1];

	// Write-back goes to the bank named by the low index bit
	assign even_we = wb.valid & wb.we & ~wb.dst[0];
	assign odd_we = wb.valid & wb.we & wb.dst[0];

	reg_bank even_bank (
		.clock(clock),
		.reset(reset),
		.we(even_we),
		.waddr(wb.dst[reg_idx_width-1:1]),
		.wdata(wb.data),
		.raddr1(row1),
		.raddr2(row2),
		.rdata1(even_rdata1),
		.rdata2(even_rdata2)
	);

	reg_bank odd_bank (
		.clock(clock),
		.reset(reset),
		.we(odd_we),
		.waddr(wb.dst[reg_idx_width-1:1]),
		.wdata(wb.data),
		.raddr1(row1),
		.raddr2(row2),
		.rdata1(odd_rdata1),
		.rdata2(odd_rdata2)
	);

	// Command fields and source indices aligned with the bank reads;
	// data words stay zero here and are filled from the banks below
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ctl <= '0;
			rd_src1 <= '0;
			rd_src2 <= '0;
		end else if (en) begin
			rd_ctl.valid <= idx_q.valid;
			rd_ctl.op <= idx_q.op;
			rd_ctl.dst <= idx_q.dst;
			rd_ctl.masked <= idx_q.masked;
			rd_ctl.mask_sel <= idx_q.mask_sel;
			rd_ctl.scalar <= idx_q.scalar;
			rd_src1 <= idx_q.src1;
			rd_src2 <= idx_q.src2;
		end
	end

	// Bank bit picks odd or even read data
	always_comb begin
		read_next = rd_ctl;
		read_next.data1 = rd_src1[0] ? odd_rdata1 : even_rdata1;
		read_next.data2 = rd_src2[0] ? odd_rdata2 : even_rdata2;
	end

	pipe_reg #(.payload_t(read_stage_t)) read_reg (
		.clock(clock),
		.reset(reset),
		.en(en),
		.d(read_next),
		.q(read_q)
	);

	//////////////////////////////
	// Execute and mask
	mask_reg mask_reg_inst (
		.clock(clock),
		.reset(reset),
		.we(mask_we),
		.widx(mask_widx),
		.wbit(mask_wbit),
		.ridx(mask_sel),
		.rbit(mask_bit)
	);

	exec_unit exec_unit_inst (
		.clock(clock),
		.reset(reset),
		.en(en),
		.stage(read_q),
		.mask_bit(mask_bit),
		.mask_sel(mask_sel),
		.wb(wb),
		.mask_we(mask_we),
		.mask_widx(mask_widx),
		.mask_wbit(mask_wbit),
		.commit(commit),
		.scalar_data(scalar_data),
		.written(written)
	);

endmodule

//--- verilog/mask_reg.sv
// Predicate mask register, set by compares and read by masked commands
module mask_reg (
	input logic clock,
	input logic reset,
	input logic we,
	input lane_pkg::mask_idx_t widx,
	input logic wbit,
	input lane_pkg::mask_idx_t ridx,
	output logic rbit
);
	import lane_pkg::*;

	logic [mask_count-1:0] mask_bits;

	// Compare result sets or clears one bit
	always_ff @(posedge clock) begin
		if (reset) begin
			mask_bits <= '0;
		end else if (we) begin
			mask_bits[widx] <= wbit;
		end
	end

	// Combinational read for the execute stage
	assign rbit = mask_bits[ridx];

endmodule

//--- verilog/pipe_reg.sv
// Pipeline stage register with enable and synchronous clear, shared by all lane stages
module pipe_reg #(
	parameter type payload_t = logic
) (
	input logic clock,
	input logic reset,
	input logic en,
	input payload_t d,
	output payload_t q
);

	// Stage advances only while the lane is enabled
	always_ff @(posedge clock) begin
		if (reset) begin
			q <= '0;
		end else if (en) begin
			q <= d;
		end
	end

	// Once out of reset, no unknown bits travel down the pipe
	q_known: assert property (
		@(posedge clock) disable iff (reset)
		!$isunknown(q)
	);

endmodule

//--- verilog/reg_bank.sv
// Register bank with two synchronous read ports and one write port
module reg_bank (
	input logic clock,
	input logic reset,
	input logic we,
	input lane_pkg::row_t waddr,
	input lane_pkg::data_t wdata,
	input lane_pkg::row_t raddr1,
	input lane_pkg::row_t raddr2,
	output lane_pkg::data_t rdata1,
	output lane_pkg::data_t rdata2
);
	import lane_pkg::*;

	data_t mem [bank_rows];

	//////////////////////////////
	// Write port
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < bank_rows; i++) begin
				mem[i] <= '0;
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	//////////////////////////////
	// Read ports
	// Same-edge write is not visible, old contents are returned
	always_ff @(posedge clock) begin
		rdata1 <= mem[raddr1];
		rdata2 <= mem[raddr2];
	end

	// Write strobe from the execute stage is always resolved
	we_known: assert property (
		@(posedge clock) disable iff (reset)
		!$isunknown(we)
	);

endmodule
